/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mipsCore
FILELIST  = mipsCore.f
OBJDIR    = obj_dir
SIMBIN    = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(SIMBIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJDIR)

/* aluExecute.sv */
`timescale 1ns/1ps

module aluExecute (
    input  logic              [31:0] rsData,
    input  logic              [31:0] rtData,
    input  logic              [15:0] imm,
    input  logic              [4:0]  shamt,
    input  logic                     extSigned,
    input  mipsPkg::srcBSelT         srcBSel,
    input  mipsPkg::aluOpT           aluOp,
    output logic              [31:0] aluResult,
    output logic                     equal,
    output logic                     less
);
    import mipsPkg::*;

    logic [31:0] extImm;
    logic [31:0] srcB;

    //////////////////////////////////////////////////
    // Operand preparation
    //////////////////////////////////////////////////

    // ori and lui take the immediate zero-extended
    assign extImm = extSigned ? {{16{imm[15]}}, imm} : {16'h0, imm};

    always_comb begin
        case (srcBSel)
            SRCB_IMM:   srcB = extImm;
            SRCB_SHAMT: srcB = {27'h0, shamt};
            default:    srcB = rtData;
        endcase
    end

    // Flags for branches and slt
    assign equal = (rsData == rtData);
    assign less  = ($signed(rsData) < $signed(rtData));

    //////////////////////////////////////////////////
    // Operations
    //////////////////////////////////////////////////

    always_comb begin
        case (aluOp)
            ALU_ADD: aluResult = rsData + srcB;
            ALU_SUB: aluResult = rsData - srcB;
            ALU_AND: aluResult = rsData & srcB;
            ALU_OR:  aluResult = rsData | srcB;
            ALU_SLT: aluResult = {31'h0, less};
            // Shift amount comes through srcB from the shamt field
            ALU_SLL: aluResult = rtData << srcB[4:0];
            ALU_LUI: aluResult = {srcB[15:0], 16'h0};
            default: aluResult = 32'h0;
        endcase
    end

endmodule

/* ctrlDecoder.sv */
`timescale 1ns/1ps

module ctrlDecoder (
    input  logic [31:0]         instr,
    output logic                regWe,
    output mipsPkg::regDstSelT  regDstSel,
    output logic                extSigned,
    output mipsPkg::srcBSelT    srcBSel,
    output mipsPkg::aluOpT      aluOp,
    output logic                memWe,
    output mipsPkg::wbSelT      wbSel,
    output mipsPkg::npcSelT     npcSel,
    output logic                branchOnEqual
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        // Defaults describe a no-op
        regWe         = 1'b0;
        regDstSel     = DST_RT;
        extSigned     = 1'b0;
        srcBSel       = SRCB_REG;
        aluOp         = ALU_ADD;
        memWe         = 1'b0;
        wbSel         = WB_ALU;
        npcSel        = NPC_SEQ;
        branchOnEqual = 1'b0;

        casez ({opcode, funct})
            {OP_RTYPE, FN_ADDU}: begin
                regWe     = 1'b1;
                regDstSel = DST_RD;
                aluOp     = ALU_ADD;
            end
            {OP_RTYPE, FN_SUBU}: begin
                regWe     = 1'b1;
                regDstSel = DST_RD;
                aluOp     = ALU_SUB;
            end
            {OP_RTYPE, FN_AND}: begin
                regWe     = 1'b1;
                regDstSel = DST_RD;
                aluOp     = ALU_AND;
            end
            {OP_RTYPE, FN_OR}: begin
                regWe     = 1'b1;
                regDstSel = DST_RD;
                aluOp     = ALU_OR;
            end
            {OP_RTYPE, FN_SLT}: begin
                regWe     = 1'b1;
                regDstSel = DST_RD;
                aluOp     = ALU_SLT;
            end
            {OP_RTYPE, FN_SLL}: begin
                regWe     = 1'b1;
                regDstSel = DST_RD;
                srcBSel   = SRCB_SHAMT;
                aluOp     = ALU_SLL;
            end
            {OP_RTYPE, FN_JR}: npcSel = NPC_REG;
            {OP_ADDIU, 6'b??????}: begin
                regWe     = 1'b1;
                extSigned = 1'b1;
                srcBSel   = SRCB_IMM;
            end
            {OP_ORI, 6'b??????}: begin
                regWe   = 1'b1;
                srcBSel = SRCB_IMM;
                aluOp   = ALU_OR;
            end
            {OP_LUI, 6'b??????}: begin
                regWe   = 1'b1;
                srcBSel = SRCB_IMM;
                aluOp   = ALU_LUI;
            end
            {OP_LW, 6'b??????}: begin
                regWe     = 1'b1;
                extSigned = 1'b1;
                srcBSel   = SRCB_IMM;
                wbSel     = WB_MEM;
            end
            {OP_SW, 6'b??????}: begin
                extSigned = 1'b1;
                srcBSel   = SRCB_IMM;
                memWe     = 1'b1;
            end
            {OP_BEQ, 6'b??????}: begin
                npcSel        = NPC_BRANCH;
                branchOnEqual = 1'b1;
            end
            {OP_BNE, 6'b??????}: npcSel = NPC_BRANCH;
            {OP_J, 6'b??????}:   npcSel = NPC_JUMP;
            {OP_JAL, 6'b??????}: begin
                regWe     = 1'b1;
                regDstSel = DST_RA;
                wbSel     = WB_LINK;
                npcSel    = NPC_JUMP;
            end
            default: ;
        endcase
    end

endmodule

/* fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit (
    input  logic             clk,
    input  logic             rst,
    input  mipsPkg::npcSelT  npcSel,
    input  logic             branchOnEqual,
    input  logic             equal,
    input  logic [15:0]      offset,
    input  logic [25:0]      jumpIndex,
    input  logic [31:0]      rsData,
    output logic [31:0]      pc
);
    import mipsPkg::*;

    logic [31:0] pcPlus4;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] nextPc;
    logic        branchTaken;

    //////////////////////////////////////////////////
    // Next PC selection
    //////////////////////////////////////////////////

    always_comb begin
        pcPlus4      = pc + 32'd4;
        // beq wants equal high, bne wants it low
        branchTaken  = (equal == branchOnEqual);
        branchTarget = pcPlus4 + {{14{offset[15]}}, offset, 2'b00};
        jumpTarget   = {pc[31:28], jumpIndex, 2'b00};

        case (npcSel)
            NPC_BRANCH: nextPc = branchTaken ? branchTarget : pcPlus4;
            NPC_JUMP:   nextPc = jumpTarget;
            NPC_REG:    nextPc = rsData;
            default:    nextPc = pcPlus4;
        endcase
    end

    // PC register
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

/* memWriteback.sv */
`timescale 1ns/1ps

module memWriteback #(
    parameter int DM_WORDS = 1024
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               memWe,
    input  mipsPkg::wbSelT     wbSel,
    input  mipsPkg::regDstSelT regDstSel,
    input  mipsPkg::regAddrT   rtAddr,
    input  mipsPkg::regAddrT   rdAddr,
    input  logic [31:0]        aluResult,
    input  logic [31:0]        storeData,
    input  logic [31:0]        pc,
    output mipsPkg::regAddrT   regWaddr,
    output logic [31:0]        regWdata
);
    import mipsPkg::*;

    localparam int IDX_W = (DM_WORDS > 1) ? $clog2(DM_WORDS) : 1;

    logic [31:0]      dataMem [DM_WORDS];
    logic [IDX_W-1:0] wordIdx;
    logic [31:0]      loadData;

    // Word index wraps around the memory depth
    assign wordIdx  = IDX_W'(aluResult[31:2] % DM_WORDS);
    assign loadData = dataMem[wordIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DM_WORDS; i++) begin
                dataMem[i] <= 32'h0;
            end
        end else if (memWe) begin
            dataMem[wordIdx] <= storeData;
        end
    end

    //////////////////////////////////////////////////
    // Writeback selection
    //////////////////////////////////////////////////

    always_comb begin
        case (regDstSel)
            DST_RD:  regWaddr = rdAddr;
            DST_RA:  regWaddr = regAddrT'(31);
            default: regWaddr = rtAddr;
        endcase

        case (wbSel)
            WB_MEM:  regWdata = loadData;
            WB_LINK: regWdata = pc + 32'd4;
            default: regWdata = aluResult;
        endcase
    end

endmodule

/* mipsCore.f */
mipsPkg.sv
ctrlDecoder.sv
fetchUnit.sv
regFile.sv
aluExecute.sv
memWriteback.sv
mipsCore.sv
mipsCore_sva.sv
tb_mipsCore.sv

/* mipsCore.sv */
`timescale 1ns/1ps

module mipsCore #(
    parameter int DM_WORDS = 1024
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [31:0]      instr,
    output logic [31:0]      instrAddr,
    output logic             regWe,
    output mipsPkg::regAddrT regWaddr,
    output logic [31:0]      regWdata
);
    import mipsPkg::*;

    // Decoder outputs
    logic      decRegWe;
    regDstSelT regDstSel;
    logic      extSigned;
    srcBSelT   srcBSel;
    aluOpT     aluOp;
    logic      memWe;
    wbSelT     wbSel;
    npcSelT    npcSel;
    logic      branchOnEqual;

    // Datapath
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] aluResult;
    logic        equal;

    // No write is reported while held in reset
    assign regWe = decRegWe & ~rst;

    //////////////////////////////////////////////////
    // Stage instances
    //////////////////////////////////////////////////

    ctrlDecoder u_ctrlDecoder (
        .instr(instr), .regWe(decRegWe), .regDstSel(regDstSel),
        .extSigned(extSigned), .srcBSel(srcBSel), .aluOp(aluOp), .memWe(memWe),
        .wbSel(wbSel), .npcSel(npcSel), .branchOnEqual(branchOnEqual)
    );

    fetchUnit u_fetchUnit (
        .clk(clk), .rst(rst), .npcSel(npcSel), .branchOnEqual(branchOnEqual),
        .equal(equal), .offset(instr[15:0]), .jumpIndex(instr[25:0]),
        .rsData(rsData), .pc(instrAddr)
    );

    regFile u_regFile (
        .clk(clk), .rst(rst), .we(regWe), .rsAddr(instr[25:21]),
        .rtAddr(instr[20:16]), .wAddr(regWaddr), .wData(regWdata),
        .rsData(rsData), .rtData(rtData)
    );

    aluExecute u_aluExecute (
        .rsData(rsData), .rtData(rtData), .imm(instr[15:0]), .shamt(instr[10:6]),
        .extSigned(extSigned), .srcBSel(srcBSel), .aluOp(aluOp),
        .aluResult(aluResult), .equal(equal), .less()
    );

    memWriteback #(.DM_WORDS(DM_WORDS)) u_memWriteback (
        .clk(clk), .rst(rst), .memWe(memWe), .wbSel(wbSel), .regDstSel(regDstSel),
        .rtAddr(instr[20:16]), .rdAddr(instr[15:11]), .aluResult(aluResult),
        .storeData(rtData), .pc(instrAddr), .regWaddr(regWaddr), .regWdata(regWdata)
    );

endmodule

/* mipsCore_sva.sv */
`timescale 1ns/1ps

module mipsCore_sva (
    input logic        clk,
    input logic        rst,
    input logic [31:0] instrAddr,
    input logic        regWe
);
    import mipsPkg::*;

    // First fetch after reset release comes from the reset vector
    resetVector: assert property (
        @(posedge clk) ($past(rst) && !rst) |-> (instrAddr == RESET_PC)
    ) else $error("instrAddr is not the reset address after reset");

    // Fetch addresses stay on word boundaries
    wordAligned: assert property (
        @(posedge clk) disable iff (rst) (instrAddr[1:0] == 2'b00)
    ) else $error("instrAddr is not word aligned");

    noWriteInReset: assert property (
        @(posedge clk) rst |-> !regWe
    ) else $error("regWe is high while rst is asserted");

endmodule

bind mipsCore mipsCore_sva u_mipsCore_sva (
    .clk(clk), .rst(rst), .instrAddr(instrAddr), .regWe(regWe)
);

/* mipsPkg.sv */
package mipsPkg;

    //////////////////////////////////////////////////
    // Reset address and register numbering
    //////////////////////////////////////////////////

    localparam logic [31:0] RESET_PC = 32'h0000_3000;

    typedef logic [4:0] regAddrT;

    // Primary opcode field in instr[31:26]
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type function field in instr[5:0]
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    //////////////////////////////////////////////////
    // Control encodings
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_LUI
    } aluOpT;

    typedef enum logic [1:0] {SRCB_REG, SRCB_IMM, SRCB_SHAMT} srcBSelT;

    typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} regDstSelT;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wbSelT;

    typedef enum logic [1:0] {NPC_SEQ, NPC_BRANCH, NPC_JUMP, NPC_REG} npcSelT;

endpackage

/* regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic              clk,
    input  logic              rst,
    input  logic              we,
    input  mipsPkg::regAddrT  rsAddr,
    input  mipsPkg::regAddrT  rtAddr,
    input  mipsPkg::regAddrT  wAddr,
    input  logic [31:0]       wData,
    output logic [31:0]       rsData,
    output logic [31:0]       rtData
);
    import mipsPkg::*;

    logic [31:0] regs [32];

    // Combinational reads with $zero fixed at zero
    assign rsData = (rsAddr == regAddrT'(0)) ? 32'h0 : regs[rsAddr];
    assign rtData = (rtAddr == regAddrT'(0)) ? 32'h0 : regs[rtAddr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (we && (wAddr != regAddrT'(0))) begin
            regs[wAddr] <= wData;
        end
    end

endmodule

/* tb_mipsCore.sv */
`timescale 1ns/1ps

module tb_mipsCore;
    import mipsPkg::*;

    localparam int NUM_ROWS     = 24;
    localparam int RESET_CYCLES = 10;
    localparam int MARGIN       = 20;
    localparam int CYCLE_LIMIT  = NUM_ROWS + RESET_CYCLES + MARGIN;
    localparam int SEED         = 32'h4428;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] instrAddr;
    logic        regWe;
    regAddrT     regWaddr;
    logic [31:0] regWdata;

    // Trace table with one row per executed instruction
    logic [31:0] pcTab    [NUM_ROWS];
    logic [31:0] instrTab [NUM_ROWS];
    logic        weTab    [NUM_ROWS];
    logic [4:0]  waddrTab [NUM_ROWS];
    logic [31:0] wdataTab [NUM_ROWS];
    logic [31:0] gpr      [32];
    int          rowCount;
    int          errCount;
    int          cycles;

    mipsCore #(.DM_WORDS(1024)) u_mipsCore (
        .clk(clk), .rst(rst), .instr(instr), .instrAddr(instrAddr),
        .regWe(regWe), .regWaddr(regWaddr), .regWdata(regWdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Instruction encoding
    //////////////////////////////////////////////////

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sh,
                                          input logic [5:0] fn);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic logic [31:0] signExtend(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // Append a row and track the register state it leaves behind
    task automatic addRow(input logic [31:0] pc, input logic [31:0] word, input logic we,
                          input logic [4:0] wa, input logic [31:0] wd);
        pcTab[rowCount]    = pc;
        instrTab[rowCount] = word;
        weTab[rowCount]    = we;
        waddrTab[rowCount] = wa;
        wdataTab[rowCount] = wd;
        if (we && wa != 5'd0) begin
            gpr[wa] = wd;
        end
        rowCount++;
    endtask

    task automatic buildTable();
        logic [15:0] rndA;
        logic [15:0] rndB;
        logic [15:0] rndC;
        rndA = 16'($urandom());
        rndB = 16'($urandom());
        rndC = 16'($urandom());
        rowCount = 0;
        for (int r = 0; r < 32; r++) begin
            gpr[r] = 32'h0;
        end
        addRow(32'h3000, iType(OP_ADDIU, 5'd0, 5'd1, rndA), 1'b1, 5'd1, signExtend(rndA));
        addRow(32'h3004, iType(OP_ADDIU, 5'd0, 5'd2, 16'hfff0), 1'b1, 5'd2, 32'hffff_fff0);
        addRow(32'h3008, iType(OP_ORI, 5'd0, 5'd3, 16'h8001), 1'b1, 5'd3, 32'h0000_8001);
        addRow(32'h300c, iType(OP_LUI, 5'd0, 5'd4, 16'h1234), 1'b1, 5'd4, 32'h1234_0000);
        addRow(32'h3010, rType(5'd1, 5'd2, 5'd5, 5'd0, FN_ADDU), 1'b1, 5'd5, gpr[1] + gpr[2]);
        addRow(32'h3014, rType(5'd1, 5'd2, 5'd6, 5'd0, FN_SUBU), 1'b1, 5'd6, gpr[1] - gpr[2]);
        addRow(32'h3018, rType(5'd3, 5'd2, 5'd7, 5'd0, FN_AND), 1'b1, 5'd7, gpr[3] & gpr[2]);
        addRow(32'h301c, rType(5'd4, 5'd3, 5'd8, 5'd0, FN_OR), 1'b1, 5'd8, gpr[4] | gpr[3]);
        addRow(32'h3020, rType(5'd2, 5'd3, 5'd9, 5'd0, FN_SLT), 1'b1, 5'd9,
               {31'h0, ($signed(gpr[2]) < $signed(gpr[3]))});
        addRow(32'h3024, rType(5'd0, 5'd3, 5'd10, 5'd4, FN_SLL), 1'b1, 5'd10, gpr[3] << 4);
        // Write to $zero is still reported but must not stick
        addRow(32'h3028, iType(OP_ADDIU, 5'd0, 5'd0, 16'h0005), 1'b1, 5'd0, 32'h5);
        addRow(32'h302c, rType(5'd0, 5'd4, 5'd11, 5'd0, FN_ADDU), 1'b1, 5'd11, gpr[4]);
        addRow(32'h3030, iType(OP_SW, 5'd0, 5'd8, 16'h0008), 1'b0, 5'd0, 32'h0);
        addRow(32'h3034, iType(OP_LW, 5'd0, 5'd12, 16'h0008), 1'b1, 5'd12, gpr[8]);
        // Taken branches land past the skipped words
        addRow(32'h3038, iType(OP_BEQ, 5'd1, 5'd1, 16'h0002), 1'b0, 5'd0, 32'h0);
        addRow(32'h3044, iType(OP_BNE, 5'd1, 5'd1, 16'h0005), 1'b0, 5'd0, 32'h0);
        addRow(32'h3048, iType(OP_BEQ, 5'd2, 5'd3, 16'h0007), 1'b0, 5'd0, 32'h0);
        addRow(32'h304c, iType(OP_BNE, 5'd2, 5'd3, 16'h0001), 1'b0, 5'd0, 32'h0);
        addRow(32'h3054, jType(OP_J, 26'h0000c18), 1'b0, 5'd0, 32'h0);
        addRow(32'h3060, jType(OP_JAL, 26'h0000c20), 1'b1, 5'd31, 32'h3064);
        addRow(32'h3080, iType(OP_ADDIU, 5'd0, 5'd13, rndB), 1'b1, 5'd13, signExtend(rndB));
        addRow(32'h3084, rType(5'd31, 5'd0, 5'd0, 5'd0, FN_JR), 1'b0, 5'd0, 32'h0);
        addRow(32'h3064, iType(OP_ADDIU, 5'd13, 5'd14, rndC), 1'b1, 5'd14,
               gpr[13] + signExtend(rndC));
        addRow(32'h3068, rType(5'd14, 5'd1, 5'd15, 5'd0, FN_ADDU), 1'b1, 5'd15,
               gpr[14] + gpr[1]);
    endtask

    task automatic checkRow(input int row);
        if (instrAddr !== pcTab[row]) begin
            $display("Error: instrAddr expected %h got %h (row %0d)",
                     pcTab[row], instrAddr, row);
            errCount++;
        end
        if (regWe !== weTab[row]) begin
            $display("Error: regWe expected %h got %h (row %0d)", weTab[row], regWe, row);
            errCount++;
        end else if (weTab[row]) begin
            if (regWaddr !== waddrTab[row]) begin
                $display("Error: regWaddr expected %h got %h (row %0d)",
                         waddrTab[row], regWaddr, row);
                errCount++;
            end
            if (regWdata !== wdataTab[row]) begin
                $display("Error: regWdata expected %h got %h (row %0d)",
                         wdataTab[row], regWdata, row);
                errCount++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        rst      = 1'b1;
        instr    = 32'h0;
        errCount = 0;
        void'($urandom(SEED));
        buildTable();
        // A writing instruction held during reset must not show
        instr = iType(OP_ADDIU, 5'd0, 5'd1, 16'h0055);
        for (int c = 0; c < RESET_CYCLES; c++) begin
            #5;
            if (regWe !== 1'b0) begin
                $display("Error: regWe expected 0 got %h during reset", regWe);
                errCount++;
            end
            @(posedge clk);
        end
        #1;
        rst = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            instr = instrTab[i];
            #5;
            checkRow(i);
            @(posedge clk);
            #1;
        end
        $display("Trace finished with %0d errors", errCount);
        if (errCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("The trace did not finish within %0d cycles", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

endmodule
